// ==== design/uart_tx_pkg.sv ====
// Shared types for the serial transmitter, fixed to 8 data bits and one start and one stop bit
`default_nettype none

package uart_tx_pkg;

    // One data byte as written by the host
    typedef logic [7:0] byte_t;

    // Frame as held in the shifter, stop bit at the top and start bit at bit 0
    typedef logic [9:0] frame_t;

    // Index of the bit on the line, 0 is the start bit and 9 the stop bit
    typedef logic [3:0] bit_cnt_t;

    // Transmit control states
    typedef enum logic [1:0] {
        idle = 2'd0,  // Waiting for the FIFO to hold a byte
        load = 2'd1,  // Frame captured, timer restarted
        send = 2'd2   // Bits going out on the line
    } tx_state_t;

endpackage

`default_nettype wire

// ==== design/model_fifo.sv ====
// Show-ahead FIFO of 2**widthu entries, usedw wraps to 0 when full and writes while full are dropped
`timescale 1ns/1ps
`default_nettype none

module model_fifo #(
    parameter int width  = 2,
    parameter int widthu = 2
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              sclr,
    input  wire logic              rdreq,
    input  wire logic              wrreq,
    input  wire logic [width-1:0]  data,
    output logic                   empty,
    output logic                   full,
    output logic [width-1:0]       q,
    output logic [widthu-1:0]      usedw
);

    localparam logic [widthu-1:0] last_used = {widthu{1'b1}};

    logic [width-1:0]  mem [2**widthu];
    logic [widthu-1:0] rd_index;
    logic [widthu-1:0] wr_index;
    logic              wr_ok;
    logic              rd_ok;

    // A write also gets in while full if the head leaves in the same cycle
    assign wr_ok = wrreq && (!full || rdreq);
    assign rd_ok = rdreq && !empty;

    assign q     = mem[rd_index];  // Head is visible before it is read
    assign empty = (usedw == '0) && !full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_index <= '0;
        end else if (sclr) begin
            rd_index <= '0;
        end else if (rd_ok) begin
            rd_index <= rd_index + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_index <= '0;
        end else if (sclr) begin
            wr_index <= '0;
        end else if (wr_ok) begin
            wr_index <= wr_index + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_index] <= data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (sclr) begin
            full <= 1'b0;
        end else if (rdreq && !wrreq && full) begin
            full <= 1'b0;
        end else if (!rdreq && wrreq && !full && usedw == last_used) begin
            full <= 1'b1;  // Last free entry taken
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            usedw <= '0;
        end else if (sclr) begin
            usedw <= '0;
        end else if (rdreq && !wrreq && !empty) begin
            usedw <= usedw - 1'b1;
        end else if (!rdreq && wrreq && !full) begin
            usedw <= usedw + 1'b1;  // Wraps to 0 as full rises
        end else if (rdreq && wrreq && empty) begin
            usedw <= {{(widthu-1){1'b0}}, 1'b1};
        end
    end

    // The two flags exclude each other
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(empty && full));

    // The count wraps to zero at full occupancy
    a_full_wraps: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> usedw == '0);

endmodule

`default_nettype wire

// ==== design/baud_timer.sv ====
// Bit period timer, clks_per_bit must be at least 2 so no tick can land in the load cycle
`timescale 1ns/1ps
`default_nettype none

module baud_timer #(
    parameter int clks_per_bit = 16
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic start,
    input  wire logic run,
    output logic      bit_tick
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] reload = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] cnt;

    // Tick in the last clock of each bit period
    assign bit_tick = run && (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start || bit_tick) begin
            cnt <= reload;  // New bit period begins
        end else if (run) begin
            cnt <= cnt - 1'b1;
        end
    end

    // A restart must never coincide with the end of a period
    a_start_no_tick: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !bit_tick);

    a_tick_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
        bit_tick |-> run);

endmodule

`default_nettype wire

// ==== design/tx_shifter.sv ====
// Frame shifter with one start and one stop bit, the line idles high after reset
`timescale 1ns/1ps
`default_nettype none

module tx_shifter (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               load,
    input  wire logic               shift,
    input  wire uart_tx_pkg::byte_t byte_in,
    output logic                    txd
);

    uart_tx_pkg::frame_t frame;

    assign txd = frame[0];  // LSB is the bit on the line

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame <= '1;
        end else if (load) begin
            frame <= {1'b1, byte_in, 1'b0};  // Stop, data, start
        end else if (shift) begin
            frame <= {1'b1, frame[$bits(frame)-1:1]};
        end
    end

    // Loading happens in idle and shifting only while a frame is timed
    a_load_shift_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(load && shift));

endmodule

`default_nettype wire

// ==== design/tx_control.sv ====
// Transmit state machine, pops one byte per frame and needs bit_tick only while run is high
`timescale 1ns/1ps
`default_nettype none

module tx_control (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic empty,
    input  wire logic bit_tick,
    output logic      rdreq,
    output logic      load,
    output logic      run,
    output logic      busy
);

    localparam uart_tx_pkg::bit_cnt_t last_bit = 4'd9;

    uart_tx_pkg::tx_state_t state;
    uart_tx_pkg::bit_cnt_t  bit_cnt;

    // Pop and capture in the same cycle, the head is already on q
    assign rdreq = (state == uart_tx_pkg::idle) && !empty;
    assign load  = rdreq;
    assign run   = (state != uart_tx_pkg::idle);
    assign busy  = run;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= uart_tx_pkg::idle;
        end else begin
            case (state)
                uart_tx_pkg::idle: begin
                    if (!empty) begin
                        state <= uart_tx_pkg::load;
                    end
                end
                uart_tx_pkg::load: begin
                    state <= uart_tx_pkg::send;
                end
                uart_tx_pkg::send: begin
                    if (bit_tick && bit_cnt == last_bit) begin
                        state <= uart_tx_pkg::idle;  // Stop bit is over
                    end
                end
                default: begin
                    state <= uart_tx_pkg::idle;
                end
            endcase
        end
    end

    // Counts the bits already finished in the current frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (state == uart_tx_pkg::send && bit_tick) begin
            if (bit_cnt == last_bit) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // The FIFO must hold a byte whenever one is popped
    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rdreq |-> !empty);

    // Timer ticks belong to the send phase only
    a_tick_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        bit_tick |-> state == uart_tx_pkg::send);

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        bit_cnt <= last_bit);

endmodule

`default_nettype wire

// ==== design/uart_tx_top.sv ====
// Writes while full with no pop are lost and sclr spares the frame already on the line
`timescale 1ns/1ps
`default_nettype none

module uart_tx_top #(
    parameter int clks_per_bit = 16,
    parameter int widthu       = 3
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               wr,
    input  wire uart_tx_pkg::byte_t wr_data,
    input  wire logic               sclr,
    output logic                    txd,
    output logic                    busy,
    output logic                    full,
    output logic [widthu-1:0]       usedw
);

    logic               empty;
    logic               rdreq;
    logic               load;
    logic               run;
    logic               bit_tick;
    uart_tx_pkg::byte_t head;  // Show-ahead byte at the FIFO output

    model_fifo #(
        .width  (8),
        .widthu (widthu)
    ) i_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .sclr  (sclr),
        .rdreq (rdreq),
        .wrreq (wr),
        .data  (wr_data),
        .empty (empty),
        .full  (full),
        .q     (head),
        .usedw (usedw)
    );

    baud_timer #(
        .clks_per_bit (clks_per_bit)
    ) i_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (load),  // Bit timing restarts with every frame
        .run      (run),
        .bit_tick (bit_tick)
    );

    tx_shifter i_shifter (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .shift   (bit_tick),
        .byte_in (head),
        .txd     (txd)
    );

    tx_control i_control (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .bit_tick (bit_tick),
        .rdreq    (rdreq),
        .load     (load),
        .run      (run),
        .busy     (busy)
    );

endmodule

`default_nettype wire

// ==== test/tb_uart_tx.sv ====
// Testbench for the serial transmitter with the default 16 clocks per bit and 8 FIFO entries
`timescale 1ns/1ps
`default_nettype none

module tb_uart_tx;

    localparam int clks_per_bit   = 16;
    localparam int widthu         = 3;
    localparam int total_frames   = 23;  // 1 + 8 + 9 + 1 + 4 over all tests
    localparam int timeout_cycles = total_frames * (10 * clks_per_bit + 2) + 2000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               wr;
    logic               sclr;
    uart_tx_pkg::byte_t wr_data;
    logic               txd;
    logic               busy;
    logic               full;
    logic [widthu-1:0]  usedw;

    uart_tx_pkg::byte_t ref_q[$];  // Bytes the FIFO accepted and still owes to the line
    uart_tx_pkg::byte_t rx_q[$];   // Bytes decoded from txd
    logic [15:0]        lfsr_state = 16'd58033;
    int                 mismatch_count    = 0;
    int                 frame_error_count = 0;
    int                 other_error_count = 0;
    int                 dropped_count     = 0;
    int                 cycle_count       = 0;

    always #4 clk = ~clk;

    uart_tx_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .wr_data (wr_data),
        .sclr    (sclr),
        .txd     (txd),
        .busy    (busy),
        .full    (full),
        .usedw   (usedw)
    );

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic random_byte(output uart_tx_pkg::byte_t b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i]       = lfsr_state[0];  // One step per bit
        end
    endtask

    task automatic check_byte(input uart_tx_pkg::byte_t got, input uart_tx_pkg::byte_t exp,
                              input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %02h, expected %02h", $time, msg, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %b, expected %b", $time, msg, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input logic [widthu-1:0] got, input logic [widthu-1:0] exp,
                               input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
            mismatch_count++;
        end
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the edge that takes the byte
    task automatic write_byte(input uart_tx_pkg::byte_t b);
        logic accepted;
        accepted = !full || !busy;  // A full FIFO frees its head at this edge only when idle
        wr       = 1'b1;
        wr_data  = b;
        if (accepted) begin
            ref_q.push_back(b);
        end else begin
            dropped_count++;
        end
        @(posedge clk);
        #1;
        wr = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy || full || usedw != '0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic compare_received(input string name);
        uart_tx_pkg::byte_t got;
        uart_tx_pkg::byte_t exp;
        while (rx_q.size() > 0) begin
            got = rx_q.pop_front();
            if (ref_q.size() == 0) begin
                $display("error in %s: byte %02h came out that was never accepted", name, got);
                other_error_count++;
            end else begin
                exp = ref_q.pop_front();
                check_byte(got, exp, name);
            end
        end
        if (ref_q.size() != 0) begin
            $display("error in %s: %0d accepted bytes never came out", name, ref_q.size());
            other_error_count++;
            ref_q.delete();
        end
    endtask

    // Samples every bit in its middle, half a clock after the edges so txd is settled
    initial begin : line_decoder
        uart_tx_pkg::byte_t data;
        @(posedge rst_n);
        forever begin
            @(negedge txd);
            repeat (clks_per_bit / 2) @(negedge clk);
            if (txd !== 1'b0) begin
                $display("frame error: the start bit at %0t is not low", $time);
                frame_error_count++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                data[i] = txd;  // LSB first
            end
            repeat (clks_per_bit) @(negedge clk);
            if (txd !== 1'b1) begin
                $display("frame error: the stop bit at %0t is not high", $time);
                frame_error_count++;
            end
            rx_q.push_back(data);
        end
    end

    task automatic single_byte_frame();
        check_bit(txd, 1'b1, "txd after reset");
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(full, 1'b0, "full after reset");
        check_count(usedw, '0, "usedw after reset");
        write_byte(8'hC5);
        check_bit(txd, 1'b1, "txd in the cycle after the write");
        @(posedge clk);
        #1;
        check_bit(txd, 1'b0, "start bit one clock after the write");
        check_bit(busy, 1'b1, "busy during the frame");
        wait_idle();
        check_bit(busy, 1'b0, "busy after the frame");
        check_bit(txd, 1'b1, "txd after the frame");
        compare_received("single byte");
    endtask

    task automatic eight_byte_stream();
        uart_tx_pkg::byte_t b;
        for (int i = 0; i < 8; i++) begin
            random_byte(b);
            write_byte(b);
        end
        wait_idle();
        compare_received("eight bytes");
    endtask

    task automatic overflow_burst();
        uart_tx_pkg::byte_t b;
        int                 dropped_before;
        dropped_before = dropped_count;
        for (int i = 0; i < 10; i++) begin
            random_byte(b);
            write_byte(b);
        end
        check_bit(full, 1'b1, "full after the burst");
        check_count(usedw, '0, "usedw while full");
        if (dropped_count == dropped_before) begin
            $display("error in overflow: no write was refused although the FIFO filled up");
            other_error_count++;
        end
        wait_idle();
        check_bit(full, 1'b0, "full after draining");
        compare_received("overflow");
    endtask

    task automatic clear_during_frame();
        uart_tx_pkg::byte_t b;
        int                 queued;
        for (int i = 0; i < 3; i++) begin
            random_byte(b);
            write_byte(b);
        end
        repeat (40) @(posedge clk);
        #1;
        check_bit(busy, 1'b1, "busy before sclr");
        queued = ref_q.size() - 1;  // The oldest byte is on the line and the rest wait in the FIFO
        check_count(usedw, widthu'(queued), "usedw before sclr");
        for (int i = 0; i < queued; i++) begin
            b = ref_q.pop_back();
        end
        sclr = 1'b1;
        @(posedge clk);
        #1;
        sclr = 1'b0;
        check_count(usedw, '0, "usedw after sclr");
        check_bit(full, 1'b0, "full after sclr");
        check_bit(busy, 1'b1, "frame still on the line after sclr");
        wait_idle();
        check_bit(busy, 1'b0, "busy after the cleared frame");
        compare_received("clear during frame");
    endtask

    task automatic writes_after_clear();
        uart_tx_pkg::byte_t b;
        for (int i = 0; i < 4; i++) begin
            random_byte(b);
            write_byte(b);
        end
        wait_idle();
        compare_received("after clear");
    endtask

    initial begin
        rst_n   = 1'b0;
        wr      = 1'b0;
        sclr    = 1'b0;
        wr_data = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        single_byte_frame();
        eight_byte_stream();
        overflow_burst();
        clear_during_frame();
        writes_after_clear();
        $display("errors: %0d mismatches, %0d frame errors, %0d other",
                 mismatch_count, frame_error_count, other_error_count);
        if (mismatch_count + frame_error_count + other_error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/uart_tx_pkg.sv
design/model_fifo.sv
design/baud_timer.sv
design/tx_shifter.sv
design/tx_control.sv
design/uart_tx_top.sv
test/tb_uart_tx.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, exits nonzero unless the run passed
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_uart_tx \
    -f sim.f

out=$(./obj_dir/Vtb_uart_tx)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
else
    exit 1
fi
